// ==== demodulate.f ====
+incdir+tb
common/demod_pkg.sv
src/rate_decoder.sv
src/csi_addr_gen.sv
demapper/llr_demapper.sv
src/llr_quantizer.sv
src/demodulate.sv
tb/tb_demodulate.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_demodulate \
    -f demodulate.f -o sim_demodulate &&
./obj_dir/sim_demodulate || exit 1

// ==== tb/demod_model.svh ====
`ifndef DEMOD_MODEL_SVH
`define DEMOD_MODEL_SVH

    // one weight per data subcarrier, read through csi_read_addr_o
    csi_t csi_table [52];

    // 64-QAM and unknown codes fall back to BPSK
    function automatic mod_t rate_to_mod(input rate_t rate);
        mod_t m;
        m = MOD_BPSK;
        if (rate[7] && (rate[3:0] == 4'd1 || rate[3:0] == 4'd2)) begin
            m = MOD_QPSK;
        end else if (rate[7] && (rate[3:0] == 4'd3 || rate[3:0] == 4'd4)) begin
            m = MOD_QAM16;
        end else if (!rate[7] && (rate[3:0] == 4'b1010 || rate[3:0] == 4'b1110)) begin
            m = MOD_QPSK;
        end else if (!rate[7] && (rate[3:0] == 4'b1001 || rate[3:0] == 4'b1101)) begin
            m = MOD_QAM16;
        end
        return m;
    endfunction

    function automatic hard_bits_t hard_decision(input mod_t m, input cons_t i, input cons_t q);
        hard_bits_t h;
        h = '0;
        h[0] = i >= 0;
        if (m == MOD_QPSK) begin
            h[1] = q >= 0;
        end else if (m == MOD_QAM16) begin
            h[1] = (i < 0 ? -int'(i) : int'(i)) < int'(QAM16_DIV);
            h[2] = q >= 0;
            h[3] = (q < 0 ? -int'(q) : int'(q)) < int'(QAM16_DIV);
        end
        return h;
    endfunction

    // piecewise linear llr of one lane on one axis
    function automatic longint raw_llr(input mod_t m, input cons_t c, input logic lane1,
                                       input logic q_axis);
        longint x;
        longint m8;
        longint off;
        longint r;
        x = longint'(c);
        m8 = longint'(QAM16_VALUE8) * x;
        off = longint'(QAM16_OFFSET);
        r = 0;
        if (m == MOD_BPSK && !lane1 && !q_axis) begin
            r = -longint'(BPSK_VALUE4) * x;
        end else if (m == MOD_QPSK && !lane1) begin
            r = -longint'(QPSK_VALUE4) * x;
        end else if (m == MOD_QAM16 && !lane1) begin
            if (x < -longint'(QAM16_VALUE2)) begin
                r = -m8 - off;
            end else if (x < longint'(QAM16_VALUE2)) begin
                r = -(m8 >>> 1);
            end else begin
                r = -m8 + off;
            end
        end else if (m == MOD_QAM16) begin
            r = (x < 0) ? -(m8 >>> 1) - off : (m8 >>> 1) - off;
        end
        return r;
    endfunction

    // weight, drop fraction bits, saturate, then count thresholds not reached
    function automatic soft_bit_t soft_value(input longint raw, input csi_t w, input logic ht);
        longint v;
        longint step;
        soft_bit_t q;
        v = (raw * longint'(w)) >>> WEIGHT_SHIFT;
        v = (v < longint'(CLIP_MIN)) ? longint'(CLIP_MIN) : v;
        v = (v > longint'(CLIP_MAX)) ? longint'(CLIP_MAX) : v;
        step = ht ? longint'(THRESH_BASE_HT) : longint'(THRESH_BASE_LEGACY);
        q = 3'd0;
        for (int k = 3; k >= -3; k--) begin
            if (v < k * step) begin
                q = q + 3'd1;
            end
        end
        return q;
    endfunction

    // packed as q1, q0, i1, i0
    function automatic logic [11:0] soft_word(input mod_t m, input cons_t i, input cons_t q,
                                              input csi_t w, input logic ht);
        return {soft_value(raw_llr(m, q, 1'b1, 1'b1), w, ht),
                soft_value(raw_llr(m, q, 1'b0, 1'b1), w, ht),
                soft_value(raw_llr(m, i, 1'b1, 1'b0), w, ht),
                soft_value(raw_llr(m, i, 1'b0, 1'b0), w, ht)};
    endfunction

    function automatic sc_addr_t next_sc_addr(input sc_addr_t a, input logic ht);
        return (a == (ht ? SC_TOP_HT : SC_TOP_LEGACY)) ? 8'd0 : a + 8'd1;
    endfunction

`endif

// ==== tb/tb_demodulate.sv ====
`timescale 1ns/10ps

module tb_demodulate;

    import demod_pkg::*;

    localparam int NUM_SAMPLES = 3000;
    // two clocks per sample plus the drain time of every rate block
    localparam int WATCHDOG_CYCLES = NUM_SAMPLES * 2 + 4000;

    logic        clock;
    logic        reset;
    logic        enable_i;
    rate_t       rate_i;
    cons_t       cons_i_i;
    cons_t       cons_q_i;
    logic        input_strobe_i;
    sc_addr_t    csi_read_addr_o;
    csi_t        csi_weight_i;
    hard_bits_t  hard_bits_o;
    logic [11:0] soft_bits_o;
    logic        output_strobe_o;

    logic [31:0] lfsr_state;
    sc_addr_t    addr_model;
    logic [3:0]  strobe_model;
    logic        last_enable;
    hard_bits_t  held_hard;
    logic [11:0] held_soft;
    hard_bits_t  hard_queue [$];
    logic [11:0] soft_queue [$];
    int          samples_sent;
    int          samples_checked;

    `include "demod_model.svh"

    demodulate u_dut (.*);

    // external CSI memory with combinational read
    assign csi_weight_i = (csi_read_addr_o < 8'd52) ? csi_table[csi_read_addr_o] : '0;

    always #2 clock = ~clock;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic expect_equal(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        assert (got == exp)
            else report_failure($sformatf("FAIL %s got %h expected %h", name, got, exp));
    endtask

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    // full range or near +-648 or near zero
    function automatic cons_t random_cons();
        logic [1:0] kind;
        int v;
        kind = 2'(lfsr_bits(2));
        v = int'(lfsr_bits(16)) - 32768;
        if (kind == 2'd2) begin
            v = int'(QAM16_VALUE2) + int'(lfsr_bits(4)) - 8;
            v = (lfsr_bits(1) != 0) ? -v : v;
        end else if (kind == 2'd3) begin
            v = int'(lfsr_bits(10)) - 512;
        end
        return cons_t'(v);
    endfunction

    function automatic csi_t random_weight();
        logic [13:0] mag;
        logic [2:0] shift;
        mag = 14'(lfsr_bits(14));
        shift = 3'(lfsr_bits(3));
        return csi_t'(mag >> shift);
    endfunction

    // all legacy and HT codes with bits 6:4 random
    function automatic rate_t pick_rate();
        logic [3:0] idx;
        logic [2:0] top;
        rate_t r;
        // no legacy code while the address is past the legacy top
        do begin
            idx = 4'(lfsr_bits(4));
            top = 3'(lfsr_bits(3));
            r = {idx[3], top, ~idx[3], idx[2:0]};
        end while (!r[7] && addr_model > SC_TOP_LEGACY);
        return r;
    endfunction

    // check what the last edge left and drive the next edge
    task automatic next_cycle(input logic en, input logic stb);
        logic exp_strobe;
        @(negedge clock);
        exp_strobe = last_enable & strobe_model[3];
        expect_equal("output_strobe_o", output_strobe_o, exp_strobe);
        expect_equal("csi_read_addr_o", csi_read_addr_o, addr_model);
        if (!last_enable) begin
            expect_equal("hard_bits_o", hard_bits_o, held_hard);
            expect_equal("soft_bits_o", soft_bits_o, held_soft);
        end
        if (output_strobe_o) begin
            expect_equal("hard_bits_o", hard_bits_o, hard_queue[0]);
            expect_equal("soft_bits_o", soft_bits_o, soft_queue[0]);
            hard_queue.delete(0);
            soft_queue.delete(0);
            samples_checked++;
        end
        held_hard = hard_bits_o;
        held_soft = soft_bits_o;
        enable_i = en;
        input_strobe_i = stb;
        cons_i_i = random_cons();
        cons_q_i = random_cons();
        if (en) begin
            strobe_model = {strobe_model[2:0], stb};
        end
        if (en && stb) begin
            addr_model = next_sc_addr(addr_model, rate_i[7]);
            hard_queue.push_back(hard_decision(rate_to_mod(rate_i), cons_i_i, cons_q_i));
            soft_queue.push_back(soft_word(rate_to_mod(rate_i), cons_i_i, cons_q_i,
                                           csi_table[addr_model], rate_i[7]));
            samples_sent++;
        end
        last_enable = en;
    endtask

    // n enabled cycles without a strobe
    task automatic idle_cycles(input int n);
        int done;
        logic en;
        done = 0;
        while (done < n) begin
            en = lfsr_bits(3) != 0;
            next_cycle(en, 1'b0);
            done = en ? done + 1 : done;
        end
    endtask

    initial begin
        int block_end;
        logic en;
        logic stb;
        lfsr_state = 32'he2dcd522;
        clock = 1'b0;
        reset = 1'b1;
        enable_i = 1'b1;
        rate_i = '0;
        cons_i_i = '0;
        cons_q_i = '0;
        input_strobe_i = 1'b0;
        addr_model = '0;
        strobe_model = '0;
        last_enable = 1'b1;
        samples_sent = 0;
        samples_checked = 0;
        for (int n = 0; n < 52; n++) begin
            csi_table[n] = random_weight();
        end
        repeat (8) @(posedge clock);
        @(negedge clock);
        // soft reset pattern i0 = 0, i1 = 4, q0 = 7, q1 = 0
        expect_equal("output_strobe_o", output_strobe_o, 1'b0);
        expect_equal("hard_bits_o", hard_bits_o, 4'h0);
        expect_equal("csi_read_addr_o", csi_read_addr_o, 8'h00);
        expect_equal("soft_bits_o", soft_bits_o, 12'h1e0);
        held_hard = hard_bits_o;
        held_soft = soft_bits_o;
        reset = 1'b0;
        while (samples_sent < NUM_SAMPLES) begin
            rate_i = pick_rate();
            idle_cycles(2);
            block_end = samples_sent + 16 + int'(lfsr_bits(6));
            while (samples_sent < block_end && samples_sent < NUM_SAMPLES) begin
                en = lfsr_bits(3) != 0;
                stb = lfsr_bits(3) != 0;
                next_cycle(en, stb);
            end
            // pipeline empty before the rate may change
            while (hard_queue.size() != 0) begin
                idle_cycles(1);
            end
            idle_cycles(6);
        end
        if (samples_checked == samples_sent && hard_queue.size() == 0) begin
            $display("test passed");
            $finish;
        end else begin
            report_failure("output strobe count differs from input strobe count");
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        report_failure("watchdog expired before all samples were checked");
    end

endmodule

// ==== src/demodulate.sv ====
`timescale 1ns/10ps

module demodulate (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  enable_i,
    input  demod_pkg::rate_t      rate_i,
    input  demod_pkg::cons_t      cons_i_i,
    input  demod_pkg::cons_t      cons_q_i,
    input  logic                  input_strobe_i,
    output demod_pkg::sc_addr_t   csi_read_addr_o,
    input  demod_pkg::csi_t       csi_weight_i,
    output demod_pkg::hard_bits_t hard_bits_o,
    output logic [11:0]           soft_bits_o,
    output logic                  output_strobe_o
);

    import demod_pkg::*;

    mod_t       mod;
    logic       is_ht;
    hard_bits_t hard_bits;
    hard_bits_t hard_dly1;
    llr_raw_t   llr_i0;
    llr_raw_t   llr_i1;
    llr_raw_t   llr_q0;
    llr_raw_t   llr_q1;
    logic [3:0] strobe_dly;

    rate_decoder u_rate_decoder (
        .clock    (clock),
        .reset    (reset),
        .enable_i (enable_i),
        .rate_i   (rate_i),
        .mod_o    (mod),
        .is_ht_o  (is_ht)
    );

    csi_addr_gen u_csi_addr_gen (
        .clock    (clock),
        .reset    (reset),
        .enable_i (enable_i),
        .strobe_i (input_strobe_i),
        .is_ht_i  (is_ht),
        .addr_o   (csi_read_addr_o)
    );

    llr_demapper u_llr_demapper (
        .clock       (clock),
        .reset       (reset),
        .enable_i    (enable_i),
        .cons_i_i    (cons_i_i),
        .cons_q_i    (cons_q_i),
        .mod_i       (mod),
        .hard_bits_o (hard_bits),
        .llr_i0_o    (llr_i0),
        .llr_i1_o    (llr_i1),
        .llr_q0_o    (llr_q0),
        .llr_q1_o    (llr_q1)
    );

    llr_quantizer u_llr_quantizer (
        .clock        (clock),
        .reset        (reset),
        .enable_i     (enable_i),
        .is_ht_i      (is_ht),
        .csi_weight_i (csi_weight_i),
        .llr_i0_i     (llr_i0),
        .llr_i1_i     (llr_i1),
        .llr_q0_i     (llr_q0),
        .llr_q1_i     (llr_q1),
        .soft_bits_o  (soft_bits_o)
    );

    // strobe follows the four pipeline stages, hard bits wait two more
    always_ff @(posedge clock) begin
        if (reset) begin
            strobe_dly  <= '0;
            hard_dly1   <= '0;
            hard_bits_o <= '0;
        end else if (enable_i) begin
            strobe_dly  <= {strobe_dly[2:0], input_strobe_i};
            hard_dly1   <= hard_bits;
            hard_bits_o <= hard_dly1;
        end
    end

    assign output_strobe_o = enable_i ? strobe_dly[3] : 1'b0;

endmodule

// ==== src/llr_quantizer.sv ====
`timescale 1ns/10ps

module llr_quantizer (
    input  logic                clock,
    input  logic                reset,
    input  logic                enable_i,
    input  logic                is_ht_i,
    input  demod_pkg::csi_t     csi_weight_i,
    input  demod_pkg::llr_raw_t llr_i0_i,
    input  demod_pkg::llr_raw_t llr_i1_i,
    input  demod_pkg::llr_raw_t llr_q0_i,
    input  demod_pkg::llr_raw_t llr_q1_i,
    output logic [11:0]         soft_bits_o
);

    import demod_pkg::*;

    csi_t      weight_q;
    llr_raw_t  llr_in [4];
    llr_wide_t prod_q [4];
    soft_bit_t soft_q [4];
    llr_clip_t step;

    // drop the fraction bits, then saturate
    function automatic llr_clip_t clip_llr(input llr_wide_t p);
        logic signed [$bits(llr_wide_t)-WEIGHT_SHIFT-1:0] s;
        s = p[$bits(llr_wide_t)-1:WEIGHT_SHIFT];
        if (s < CLIP_MIN) begin
            return CLIP_MIN;
        end else if (s > CLIP_MAX) begin
            return CLIP_MAX;
        end
        return llr_clip_t'(s);
    endfunction

    // 7 below -3*step, one less per threshold passed, 0 from 3*step up
    function automatic soft_bit_t quantize(input llr_clip_t v, input llr_clip_t s);
        soft_bit_t q;
        q = 3'd7;
        for (int k = -3; k <= 3; k++) begin
            if (int'(v) >= k * int'(s)) begin
                q = q - 3'd1;
            end
        end
        return q;
    endfunction

    assign llr_in[0] = llr_i0_i;
    assign llr_in[1] = llr_i1_i;
    assign llr_in[2] = llr_q0_i;
    assign llr_in[3] = llr_q1_i;

    assign step = is_ht_i ? THRESH_BASE_HT : THRESH_BASE_LEGACY;

    // weight read for the incremented address lines up with the raw llr
    always_ff @(posedge clock) begin
        if (enable_i) begin
            weight_q <= csi_weight_i;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int n = 0; n < 4; n++) begin
                prod_q[n] <= '0;
            end
        end else if (enable_i) begin
            for (int n = 0; n < 4; n++) begin
                prod_q[n] <= llr_in[n] * weight_q;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            soft_q[0] <= 3'd0;
            soft_q[1] <= 3'd4;
            soft_q[2] <= 3'd7;
            soft_q[3] <= 3'd0;
        end else if (enable_i) begin
            for (int n = 0; n < 4; n++) begin
                soft_q[n] <= quantize(clip_llr(prod_q[n]), step);
            end
        end
    end

    // packed as q1, q0, i1, i0
    assign soft_bits_o = {soft_q[3], soft_q[2], soft_q[1], soft_q[0]};

endmodule

// ==== demapper/llr_demapper.sv ====
`timescale 1ns/10ps

module llr_demapper (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  enable_i,
    input  demod_pkg::cons_t      cons_i_i,
    input  demod_pkg::cons_t      cons_q_i,
    input  demod_pkg::mod_t       mod_i,
    output demod_pkg::hard_bits_t hard_bits_o,
    output demod_pkg::llr_raw_t   llr_i0_o,
    output demod_pkg::llr_raw_t   llr_i1_o,
    output demod_pkg::llr_raw_t   llr_q0_o,
    output demod_pkg::llr_raw_t   llr_q1_o
);

    import demod_pkg::*;

    cons_t       cons_i_q;
    cons_t       cons_q_q;
    logic [15:0] abs_i_q;
    logic [15:0] abs_q_q;

    llr_raw_t   m8_i;
    llr_raw_t   m8_q;
    hard_bits_t hard_d;
    llr_raw_t   llr_i0_d;
    llr_raw_t   llr_i1_d;
    llr_raw_t   llr_q0_d;
    llr_raw_t   llr_q1_d;

    // 16-QAM first bit, three linear segments
    function automatic llr_raw_t qam16_lane0(input cons_t x, input llr_raw_t m8);
        llr_raw_t m4;
        m4 = m8 >>> 1;
        if (x < -QAM16_VALUE2) begin
            return -m8 - QAM16_OFFSET;
        end else if (x < QAM16_VALUE2) begin
            return -m4;
        end
        return -m8 + QAM16_OFFSET;
    endfunction

    // 16-QAM second bit, symmetric around zero
    function automatic llr_raw_t qam16_lane1(input cons_t x, input llr_raw_t m8);
        llr_raw_t m4;
        m4 = m8 >>> 1;
        if (x < 0) begin
            return -m4 - QAM16_OFFSET;
        end
        return m4 - QAM16_OFFSET;
    endfunction

    // input stage
    always_ff @(posedge clock) begin
        if (reset) begin
            cons_i_q <= '0;
            cons_q_q <= '0;
            abs_i_q  <= '0;
            abs_q_q  <= '0;
        end else if (enable_i) begin
            cons_i_q <= cons_i_i;
            cons_q_q <= cons_q_i;
            abs_i_q  <= cons_i_i[15] ? -cons_i_i : cons_i_i;
            abs_q_q  <= cons_q_i[15] ? -cons_q_i : cons_q_i;
        end
    end

    assign m8_i = QAM16_VALUE8 * cons_i_q;
    assign m8_q = QAM16_VALUE8 * cons_q_q;

    always_comb begin
        hard_d   = '0;
        llr_i0_d = '0;
        llr_i1_d = '0;
        llr_q0_d = '0;
        llr_q1_d = '0;
        case (mod_i)
            MOD_QPSK: begin
                hard_d[0] = ~cons_i_q[15];
                hard_d[1] = ~cons_q_q[15];
                llr_i0_d  = -QPSK_VALUE4 * cons_i_q;
                llr_q0_d  = -QPSK_VALUE4 * cons_q_q;
            end
            MOD_QAM16: begin
                hard_d[0] = ~cons_i_q[15];
                hard_d[1] = abs_i_q < QAM16_DIV;
                hard_d[2] = ~cons_q_q[15];
                hard_d[3] = abs_q_q < QAM16_DIV;
                llr_i0_d  = qam16_lane0(cons_i_q, m8_i);
                llr_i1_d  = qam16_lane1(cons_i_q, m8_i);
                llr_q0_d  = qam16_lane0(cons_q_q, m8_q);
                llr_q1_d  = qam16_lane1(cons_q_q, m8_q);
            end
            // BPSK uses the I axis only
            default: begin
                hard_d[0] = ~cons_i_q[15];
                llr_i0_d  = -BPSK_VALUE4 * cons_i_q;
            end
        endcase
    end

    // decision stage
    always_ff @(posedge clock) begin
        if (reset) begin
            hard_bits_o <= '0;
            llr_i0_o    <= '0;
            llr_i1_o    <= '0;
            llr_q0_o    <= '0;
            llr_q1_o    <= '0;
        end else if (enable_i) begin
            hard_bits_o <= hard_d;
            llr_i0_o    <= llr_i0_d;
            llr_i1_o    <= llr_i1_d;
            llr_q0_o    <= llr_q0_d;
            llr_q1_o    <= llr_q1_d;
        end
    end

endmodule

// ==== src/csi_addr_gen.sv ====
`timescale 1ns/10ps

module csi_addr_gen (
    input  logic                clock,
    input  logic                reset,
    input  logic                enable_i,
    input  logic                strobe_i,
    input  logic                is_ht_i,
    output demod_pkg::sc_addr_t addr_o
);

    import demod_pkg::*;

    sc_addr_t addr_top;

    // HT symbols carry four more data subcarriers
    assign addr_top = is_ht_i ? SC_TOP_HT : SC_TOP_LEGACY;

    always_ff @(posedge clock) begin
        if (reset) begin
            addr_o <= '0;
        end else if (enable_i && strobe_i) begin
            if (addr_o == addr_top) begin
                addr_o <= '0;
            end else begin
                addr_o <= addr_o + 8'd1;
            end
        end
    end

endmodule

// ==== src/rate_decoder.sv ====
`timescale 1ns/10ps

module rate_decoder (
    input  logic             clock,
    input  logic             reset,
    input  logic             enable_i,
    input  demod_pkg::rate_t rate_i,
    output demod_pkg::mod_t  mod_o,
    output logic             is_ht_o
);

    import demod_pkg::*;

    mod_t mod_d;

    // HT flag plus low nibble selects the constellation
    always_comb begin
        case ({rate_i[7], rate_i[3:0]})
            // legacy 6/9, 12/18, 24/36 Mbps
            5'b01011: mod_d = MOD_BPSK;
            5'b01111: mod_d = MOD_BPSK;
            5'b01010: mod_d = MOD_QPSK;
            5'b01110: mod_d = MOD_QPSK;
            5'b01001: mod_d = MOD_QAM16;
            5'b01101: mod_d = MOD_QAM16;
            // HT MCS 0 to 4
            5'b10000: mod_d = MOD_BPSK;
            5'b10001: mod_d = MOD_QPSK;
            5'b10010: mod_d = MOD_QPSK;
            5'b10011: mod_d = MOD_QAM16;
            5'b10100: mod_d = MOD_QAM16;
            // 64-QAM and unknown codes
            default:  mod_d = MOD_BPSK;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            mod_o   <= MOD_BPSK;
            is_ht_o <= 1'b0;
        end else if (enable_i) begin
            mod_o   <= mod_d;
            is_ht_o <= rate_i[7];
        end
    end

endmodule

// ==== common/demod_pkg.sv ====
package demod_pkg;

    // sample and weight widths
    typedef logic signed [15:0] cons_t;
    typedef logic signed [33:0] csi_t;

    // llr path widths
    typedef logic signed [28:0] llr_raw_t;
    typedef logic signed [62:0] llr_wide_t;
    typedef logic signed [12:0] llr_clip_t;
    typedef logic [2:0] soft_bit_t;

    // hard decisions, two per axis at most
    typedef logic [3:0] hard_bits_t;

    typedef logic [7:0] sc_addr_t;

    // bit 7 marks HT, bits 3:0 select the rate
    typedef logic [7:0] rate_t;

    typedef enum logic [1:0] {
        MOD_BPSK,
        MOD_QPSK,
        MOD_QAM16
    } mod_t;

    // slope for BPSK, constellation at -1, 1 with unit 1024
    localparam llr_raw_t BPSK_VALUE4 = 29'sd4096;

    // slope for QPSK, unit 1024/sqrt(2)
    localparam llr_raw_t QPSK_VALUE4 = 29'sd2896;

    // 16-QAM, unit 1024/sqrt(10)
    localparam logic [15:0] QAM16_DIV = 16'd648;
    localparam cons_t QAM16_VALUE2 = 16'sd648;
    localparam llr_raw_t QAM16_VALUE8 = 29'sd2591;

    // 8 * 1024 * 1024 / 10, rounded
    localparam llr_raw_t QAM16_OFFSET = 29'sd838861;

    // quantizer step sizes
    localparam llr_clip_t THRESH_BASE_LEGACY = 13'sd413;
    localparam llr_clip_t THRESH_BASE_HT = 13'sd550;

    // last data subcarrier index, 48 legacy or 52 HT
    localparam sc_addr_t SC_TOP_LEGACY = 8'd47;
    localparam sc_addr_t SC_TOP_HT = 8'd51;

    // saturation range of the weighted llr
    localparam llr_clip_t CLIP_MIN = -13'sd2048;
    localparam llr_clip_t CLIP_MAX = 13'sd2047;

    // low product bits dropped after weighting
    localparam int WEIGHT_SHIFT = 16;

endpackage
